// File: sim.f
logic/definitions.sv
logic/store_buffer_if.sv
logic/decode.sv
logic/forwarding.sv
logic/store_buffer.sv
logic/control.sv
logic/pipeline_control_top.sv
testbench/control_tb.sv

// File: Makefile
TOP = control_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: testbench/control_tb.sv
`default_nettype none
`timescale 1ns/100ps

module control_tb;
	localparam int SB_DEPTH   = 4;
	localparam int CYCLES     = 2000;
	localparam int DRAIN_WAIT = 50;

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;

	logic        clk_i;
	logic        reset_i;
	logic        id_valid_i;
	logic [31:0] id_instr_i;
	logic        ex_valid_i;
	logic        ex_regfile_we_i;
	logic [4:0]  ex_wr_addr_i;
	logic        ex_is_load_i;
	logic        mem_valid_i;
	logic        mem_regfile_we_i;
	logic [4:0]  mem_wr_addr_i;
	logic        mem_is_jump_i;
	logic        mem_is_branch_i;
	logic        mem_cmp_res_i;
	logic        mem_is_mem_access_i;
	logic        mem_dcache_wr_enable_i;
	logic [31:0] mem_addr_i;
	logic [31:0] mem_wdata_i;
	logic        wb_valid_i;
	logic        wb_regfile_we_i;
	logic [4:0]  wb_wr_addr_i;
	logic        icache_hit_i;
	logic        dcache_hit_i;
	logic [1:0]  reg1_bypass_o;
	logic [1:0]  reg2_bypass_o;
	logic        next_pc_sel_o;
	logic        pc_stall_o;
	logic        id_stall_o;
	logic        ex_stall_o;
	logic        mem_stall_o;
	logic        id_valid_o;
	logic        ex_valid_o;
	logic        mem_valid_o;
	logic        wb_valid_o;
	logic        use_sb_data_o;
	logic [31:0] sb_snoop_data_o;
	logic [19:0] decode_o;
	logic        sb_drain_valid_o;
	logic [31:0] sb_drain_addr_o;
	logic [31:0] sb_drain_data_o;

	logic [15:0] lfsr_state;
	logic [31:0] q_addr [$]; // Model store queue, head at index 0.
	logic [31:0] q_data [$];
	int          waited;

	pipeline_control_top pipeline_control_top_inst (
		.clk_i                 (clk_i),
		.reset_i               (reset_i),
		.id_valid_i            (id_valid_i),
		.id_instr_i            (id_instr_i),
		.ex_valid_i            (ex_valid_i),
		.ex_regfile_we_i       (ex_regfile_we_i),
		.ex_wr_addr_i          (ex_wr_addr_i),
		.ex_is_load_i          (ex_is_load_i),
		.mem_valid_i           (mem_valid_i),
		.mem_regfile_we_i      (mem_regfile_we_i),
		.mem_wr_addr_i         (mem_wr_addr_i),
		.mem_is_jump_i         (mem_is_jump_i),
		.mem_is_branch_i       (mem_is_branch_i),
		.mem_cmp_res_i         (mem_cmp_res_i),
		.mem_is_mem_access_i   (mem_is_mem_access_i),
		.mem_dcache_wr_enable_i(mem_dcache_wr_enable_i),
		.mem_addr_i            (mem_addr_i),
		.mem_wdata_i           (mem_wdata_i),
		.wb_valid_i            (wb_valid_i),
		.wb_regfile_we_i       (wb_regfile_we_i),
		.wb_wr_addr_i          (wb_wr_addr_i),
		.icache_hit_i          (icache_hit_i),
		.dcache_hit_i          (dcache_hit_i),
		.reg1_bypass_o         (reg1_bypass_o),
		.reg2_bypass_o         (reg2_bypass_o),
		.next_pc_sel_o         (next_pc_sel_o),
		.pc_stall_o            (pc_stall_o),
		.id_stall_o            (id_stall_o),
		.ex_stall_o            (ex_stall_o),
		.mem_stall_o           (mem_stall_o),
		.id_valid_o            (id_valid_o),
		.ex_valid_o            (ex_valid_o),
		.mem_valid_o           (mem_valid_o),
		.wb_valid_o            (wb_valid_o),
		.use_sb_data_o         (use_sb_data_o),
		.sb_snoop_data_o       (sb_snoop_data_o),
		.decode_o              (decode_o),
		.sb_drain_valid_o      (sb_drain_valid_o),
		.sb_drain_addr_o       (sb_drain_addr_o),
		.sb_drain_data_o       (sb_drain_data_o)
	);

	initial clk_i = 1'b0;
	always #5 clk_i = ~clk_i;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Random source
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1.
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [6:0] pick_opcode(input logic [3:0] idx);
		case (idx)
			4'd0:    return OP_REG;
			4'd1:    return OP_IMM;
			4'd2:    return OP_LOAD;
			4'd3:    return OP_JALR;
			4'd4:    return OP_STORE;
			4'd5:    return OP_BRANCH;
			4'd6:    return OP_JAL;
			4'd7:    return OP_LUI;
			default: return OP_AUIPC;
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fields as {rs1, rs2, rd, uses_rs1, uses_rs2, class}.
	function automatic logic [19:0] model_decode(input logic [31:0] ins);
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		rs1 = ins[19:15];
		rs2 = ins[24:20];
		rd  = ins[11:7];
		case (ins[6:0])
			OP_REG:    return {rs1, rs2, rd, 2'b11, 3'd0};
			OP_IMM:    return {rs1, 5'd0, rd, 2'b10, 3'd0};
			OP_LOAD:   return {rs1, 5'd0, rd, 2'b10, 3'd1};
			OP_JALR:   return {rs1, 5'd0, rd, 2'b10, 3'd4};
			OP_STORE:  return {rs1, rs2, 5'd0, 2'b11, 3'd2};
			OP_BRANCH: return {rs1, rs2, 5'd0, 2'b11, 3'd3};
			OP_JAL:    return {10'd0, rd, 2'b00, 3'd4};
			OP_LUI, OP_AUIPC:
				return {10'd0, rd, 5'd0};
			default:   return '0;
		endcase
	endfunction

	// EX first, then MEM, then WB. A load in EX has no data yet.
	function automatic logic [1:0] select_bypass(input logic [4:0] src, input logic used);
		if (!used || src == 5'd0)
			return 2'd0;
		if (ex_valid_i && ex_regfile_we_i && !ex_is_load_i && ex_wr_addr_i == src)
			return 2'd1;
		if (mem_valid_i && mem_regfile_we_i && mem_wr_addr_i == src)
			return 2'd2;
		if (wb_valid_i && wb_regfile_we_i && wb_wr_addr_i == src)
			return 2'd3;
		return 2'd0;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
			$display("Simulation failed");
			$fatal(1, "Output mismatch at time %0t", $time);
		end
	endtask

	task automatic check_cycle();
		logic [19:0] dec;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic        dh;
		logic        ch;
		logic        vload;
		logic        vstore;
		logic        hit;
		logic        line;
		logic [31:0] sdata;
		logic        full;
		logic        mstall;
		logic        put;
		logic        get;

		dec = model_decode(id_instr_i);
		rs1 = dec[19:15];
		rs2 = dec[14:10];
		dh  = ex_valid_i && ex_regfile_we_i && ex_is_load_i && ex_wr_addr_i != 5'd0 &&
			((dec[4] && rs1 == ex_wr_addr_i) || (dec[3] && rs2 == ex_wr_addr_i));
		ch  = mem_valid_i && (mem_is_jump_i || (mem_is_branch_i && mem_cmp_res_i));

		hit   = 1'b0;
		line  = 1'b0;
		sdata = '0;
		foreach (q_addr[i]) begin // Oldest to youngest.
			if (q_addr[i][31:2] == mem_addr_i[31:2]) begin
				hit   = 1'b1;
				sdata = q_data[i];
			end
			if (q_addr[i][31:4] == mem_addr_i[31:4])
				line = 1'b1;
		end

		full   = (q_addr.size() == SB_DEPTH);
		vload  = mem_valid_i && mem_is_mem_access_i && !mem_dcache_wr_enable_i;
		vstore = mem_valid_i && mem_is_mem_access_i && mem_dcache_wr_enable_i;
		mstall = (vload && !dcache_hit_i && !hit) || (vload && line && !hit) ||
			(vstore && full);
		put    = vstore && !full;
		get    = (!vload && q_addr.size() != 0) || (vload && line && !hit);

		check_value("decode_o", 32'(decode_o), 32'(dec));
		check_value("reg1_bypass_o", 32'(reg1_bypass_o), 32'(select_bypass(rs1, dec[4])));
		check_value("reg2_bypass_o", 32'(reg2_bypass_o), 32'(select_bypass(rs2, dec[3])));
		check_value("next_pc_sel_o", 32'(next_pc_sel_o), 32'(ch));
		check_value("pc_stall_o", 32'(pc_stall_o), 32'((dh && !ch) || !icache_hit_i || mstall));
		check_value("id_stall_o", 32'(id_stall_o), 32'((dh && !ch) || mstall));
		check_value("ex_stall_o", 32'(ex_stall_o), 32'(mstall));
		check_value("mem_stall_o", 32'(mem_stall_o), 32'(mstall || (!icache_hit_i && ch)));
		check_value("id_valid_o", 32'(id_valid_o), 32'(!ch && icache_hit_i));
		check_value("ex_valid_o", 32'(ex_valid_o), 32'(id_valid_i && !dh && !ch));
		check_value("mem_valid_o", 32'(mem_valid_o), 32'(ex_valid_i && !ch));
		check_value("wb_valid_o", 32'(wb_valid_o), 32'(mem_valid_i && !mstall));
		check_value("use_sb_data_o", 32'(use_sb_data_o), 32'(vload && hit));
		check_value("sb_snoop_data_o", sb_snoop_data_o, sdata);
		check_value("sb_drain_valid_o", 32'(sb_drain_valid_o), 32'(get));

		if (get) begin
			check_value("sb_drain_addr_o", sb_drain_addr_o, q_addr[0]);
			check_value("sb_drain_data_o", sb_drain_data_o, q_data[0]);
			void'(q_addr.pop_front());
			void'(q_data.pop_front());
		end
		if (put) begin
			q_addr.push_back(mem_addr_i);
			q_data.push_back(mem_wdata_i);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic drive_idle();
		id_valid_i             = 1'b0;
		id_instr_i             = '0;
		ex_valid_i             = 1'b0;
		ex_regfile_we_i        = 1'b0;
		ex_wr_addr_i           = '0;
		ex_is_load_i           = 1'b0;
		mem_valid_i            = 1'b0;
		mem_regfile_we_i       = 1'b0;
		mem_wr_addr_i          = '0;
		mem_is_jump_i          = 1'b0;
		mem_is_branch_i        = 1'b0;
		mem_cmp_res_i          = 1'b0;
		mem_is_mem_access_i    = 1'b0;
		mem_dcache_wr_enable_i = 1'b0;
		mem_addr_i             = '0;
		mem_wdata_i            = '0;
		wb_valid_i             = 1'b0;
		wb_regfile_we_i        = 1'b0;
		wb_wr_addr_i           = '0;
		icache_hit_i           = 1'b1;
		dcache_hit_i           = 1'b1;
	endtask

	task automatic drive_random();
		logic [31:0] instr;
		instr        = rand_bits(32);
		instr[6:0]   = pick_opcode(4'(rand_bits(4) % 9));
		instr[19:15] = 5'(rand_bits(2)); // Few registers, so hazards are common.
		instr[24:20] = 5'(rand_bits(2));
		id_valid_i   = rand_bits(2) != 0;
		id_instr_i   = instr;

		ex_valid_i      = rand_bits(2) != 0;
		ex_regfile_we_i = rand_bits(2) != 0;
		ex_wr_addr_i    = 5'(rand_bits(2));
		ex_is_load_i    = rand_bits(2) == 0;

		mem_valid_i            = rand_bits(2) != 0;
		mem_regfile_we_i       = rand_bits(2) != 0;
		mem_wr_addr_i          = 5'(rand_bits(2));
		mem_is_jump_i          = rand_bits(3) == 0;
		mem_is_branch_i        = rand_bits(2) == 0;
		mem_cmp_res_i          = rand_bits(1) != 0;
		mem_is_mem_access_i    = rand_bits(1) != 0;
		mem_dcache_wr_enable_i = rand_bits(1) != 0;
		mem_addr_i             = 32'h0000_1000 + rand_bits(5); // 8 words, 2 lines.
		mem_wdata_i            = rand_bits(32);

		wb_valid_i      = rand_bits(2) != 0;
		wb_regfile_we_i = rand_bits(2) != 0;
		wb_wr_addr_i    = 5'(rand_bits(2));
		icache_hit_i    = rand_bits(3) != 0;
		dcache_hit_i    = rand_bits(1) != 0;
	endtask

	initial begin
		lfsr_state = 16'd74;
		reset_i    = 1'b1;
		drive_idle();
		repeat (5) @(posedge clk_i);
		#1;
		reset_i = 1'b0;

		for (int c = 0; c < CYCLES; c++) begin
			drive_random();
			#1;
			check_cycle();
			@(posedge clk_i);
			#1;
		end

		// Idle pipeline lets the buffer drain one store per cycle.
		drive_idle();
		#1;
		check_cycle();
		waited = 0;
		while (q_addr.size() != 0 && waited < DRAIN_WAIT) begin
			@(posedge clk_i);
			#2;
			check_cycle();
			waited++;
		end

		if (q_addr.size() != 0) begin
			$display("Store buffer still holds %0d stores after %0d idle cycles",
				q_addr.size(), DRAIN_WAIT);
			$display("Simulation failed");
			$fatal(1, "Store buffer did not drain");
		end else begin
			@(posedge clk_i);
			#2;
			check_cycle();
			$display("Simulation passed");
			$finish;
		end
	end
endmodule

`default_nettype wire

// File: logic/pipeline_control_top.sv
`default_nettype none
`timescale 1ns/100ps

module pipeline_control_top
	import definitions::*;
#(
	parameter int SB_DEPTH   = 4,
	parameter int LINE_BYTES = 16
) (
	input  logic              clk_i,
	input  logic              reset_i,
	input  logic              id_valid_i,
	input  logic       [31:0] id_instr_i,
	input  logic              ex_valid_i,
	input  logic              ex_regfile_we_i,
	input  logic       [4:0]  ex_wr_addr_i,
	input  logic              ex_is_load_i,
	input  logic              mem_valid_i,
	input  logic              mem_regfile_we_i,
	input  logic       [4:0]  mem_wr_addr_i,
	input  logic              mem_is_jump_i,
	input  logic              mem_is_branch_i,
	input  logic              mem_cmp_res_i,
	input  logic              mem_is_mem_access_i,
	input  logic              mem_dcache_wr_enable_i,
	input  logic       [31:0] mem_addr_i,
	input  logic       [31:0] mem_wdata_i,
	input  logic              wb_valid_i,
	input  logic              wb_regfile_we_i,
	input  logic       [4:0]  wb_wr_addr_i,
	input  logic              icache_hit_i,
	input  logic              dcache_hit_i,
	output logic       [1:0]  reg1_bypass_o,
	output logic       [1:0]  reg2_bypass_o,
	output logic              next_pc_sel_o,
	output logic              pc_stall_o,
	output logic              id_stall_o,
	output logic              ex_stall_o,
	output logic              mem_stall_o,
	output logic              id_valid_o,
	output logic              ex_valid_o,
	output logic              mem_valid_o,
	output logic              wb_valid_o,
	output logic              use_sb_data_o,
	output logic       [31:0] sb_snoop_data_o,
	output decode_out_t       decode_o,
	output logic              sb_drain_valid_o,
	output logic       [31:0] sb_drain_addr_o,
	output logic       [31:0] sb_drain_data_o
);
	pipeline_id_reg_t  id_reg;
	pipeline_ex_reg_t  ex_reg;
	pipeline_mem_reg_t mem_reg;
	pipeline_wb_reg_t  wb_reg;
	pipeline_control_t ctrl;

	store_buffer_if sb_if (
		.clk_i  (clk_i),
		.reset_i(reset_i)
	);

	assign id_reg.valid = id_valid_i;
	assign id_reg.instr = id_instr_i;

	assign ex_reg = '{
		valid:           ex_valid_i,
		regfile_we:      ex_regfile_we_i,
		regfile_wr_addr: ex_wr_addr_i,
		is_load:         ex_is_load_i
	};

	assign mem_reg = '{
		valid:            mem_valid_i,
		regfile_we:       mem_regfile_we_i,
		regfile_wr_addr:  mem_wr_addr_i,
		is_jump:          mem_is_jump_i,
		is_branch:        mem_is_branch_i,
		cmp_unit_res:     mem_cmp_res_i,
		is_mem_access:    mem_is_mem_access_i,
		dcache_wr_enable: mem_dcache_wr_enable_i,
		addr:             mem_addr_i,
		wdata:            mem_wdata_i
	};

	assign wb_reg = '{
		valid:           wb_valid_i,
		regfile_we:      wb_regfile_we_i,
		regfile_wr_addr: wb_wr_addr_i
	};

	control control_inst (
		.id_reg_i    (id_reg),
		.ex_reg_i    (ex_reg),
		.mem_reg_i   (mem_reg),
		.wb_reg_i    (wb_reg),
		.icache_hit_i(icache_hit_i),
		.dcache_hit_i(dcache_hit_i),
		.sb          (sb_if.ctrl),
		.control_o   (ctrl),
		.decode_o    (decode_o)
	);

	store_buffer #(
		.SB_DEPTH  (SB_DEPTH),
		.LINE_BYTES(LINE_BYTES)
	) store_buffer_inst (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.sb           (sb_if.buffer),
		.put_addr_i   (mem_addr_i),
		.put_data_i   (mem_wdata_i),
		.drain_valid_o(sb_drain_valid_o),
		.drain_addr_o (sb_drain_addr_o),
		.drain_data_o (sb_drain_data_o)
	);

	assign reg1_bypass_o   = ctrl.reg1_bypass;
	assign reg2_bypass_o   = ctrl.reg2_bypass;
	assign next_pc_sel_o   = ctrl.next_pc_sel;
	assign pc_stall_o      = ctrl.pc_reg_stall;
	assign id_stall_o      = ctrl.id_reg_stall;
	assign ex_stall_o      = ctrl.ex_reg_stall;
	assign mem_stall_o     = ctrl.mem_reg_stall;
	assign id_valid_o      = ctrl.id_reg_valid;
	assign ex_valid_o      = ctrl.ex_reg_valid;
	assign mem_valid_o     = ctrl.mem_reg_valid;
	assign wb_valid_o      = ctrl.wb_reg_valid;
	assign use_sb_data_o   = ctrl.mem_use_sb_snoop_data;
	assign sb_snoop_data_o = sb_if.snoop_data;
endmodule

`default_nettype wire

// File: logic/control.sv
`default_nettype none
`timescale 1ns/100ps

module control
	import definitions::*;
(
	input  pipeline_id_reg_t  id_reg_i,
	input  pipeline_ex_reg_t  ex_reg_i,
	input  pipeline_mem_reg_t mem_reg_i,
	input  pipeline_wb_reg_t  wb_reg_i,
	input  logic              icache_hit_i,
	input  logic              dcache_hit_i,
	store_buffer_if.ctrl      sb,
	output pipeline_control_t control_o,
	output decode_out_t       decode_o
);
	alu_out_bypass_t reg1_bypass;
	alu_out_bypass_t reg2_bypass;
	logic            ex_data_hazard;
	logic            data_hazard;
	logic            control_hazard;
	logic            icache_busy;
	logic            valid_mem_access;
	logic            valid_load;
	logic            valid_store;
	logic            load_miss;
	logic            load_line_conflict;
	logic            store_on_full;
	logic            mem_stall;

	decode decode_inst (
		.instr_i (id_reg_i.instr),
		.decode_o(decode_o)
	);

	forwarding forwarding_inst (
		.id_reg_i     (id_reg_i),
		.ex_reg_i     (ex_reg_i),
		.mem_reg_i    (mem_reg_i),
		.wb_reg_i     (wb_reg_i),
		.reg1_bypass_o(reg1_bypass),
		.reg2_bypass_o(reg2_bypass)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Hazards
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign ex_data_hazard = ex_reg_i.valid && ex_reg_i.regfile_we &&
		(data_hazard_raw_check(decode_o.rs1, decode_o.uses_rs1, ex_reg_i.regfile_wr_addr) ||
		 data_hazard_raw_check(decode_o.rs2, decode_o.uses_rs2, ex_reg_i.regfile_wr_addr));

	// MEM and WB always forward. Only a load in EX leaves a gap.
	assign data_hazard = ex_data_hazard && (reg1_bypass != FROM_EX) && (reg2_bypass != FROM_EX);

	assign control_hazard = mem_reg_i.valid &&
		(mem_reg_i.is_jump || (mem_reg_i.is_branch && mem_reg_i.cmp_unit_res));

	assign icache_busy = !icache_hit_i;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory stage and store buffer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign valid_mem_access   = mem_reg_i.valid && mem_reg_i.is_mem_access;
	assign valid_load         = valid_mem_access && !mem_reg_i.dcache_wr_enable;
	assign valid_store        = valid_mem_access && mem_reg_i.dcache_wr_enable;
	assign load_miss          = valid_load && !dcache_hit_i && !sb.snoop_hit;
	assign load_line_conflict = valid_load && sb.snoop_line_conflict; // Drain first.
	assign store_on_full      = valid_store && sb.full;
	assign mem_stall          = load_miss || load_line_conflict || store_on_full;

	assign sb.snoop_addr = mem_reg_i.addr;
	assign sb.put_enable = valid_store && !sb.full;
	assign sb.get_enable = (!valid_load && !sb.empty) || load_line_conflict;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Interlock
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign control_o.reg1_bypass = reg1_bypass;
	assign control_o.reg2_bypass = reg2_bypass;
	assign control_o.next_pc_sel = control_hazard ? ALU_OUT : PC_4;

	assign control_o.pc_reg_stall  = (data_hazard && !control_hazard) || icache_busy || mem_stall;
	assign control_o.id_reg_stall  = (data_hazard && !control_hazard) || mem_stall;
	assign control_o.ex_reg_stall  = mem_stall;
	assign control_o.mem_reg_stall = mem_stall || (icache_busy && control_hazard);

	assign control_o.id_reg_valid  = !control_hazard && !icache_busy;
	assign control_o.ex_reg_valid  = id_reg_i.valid && !data_hazard && !control_hazard;
	assign control_o.mem_reg_valid = ex_reg_i.valid && !control_hazard;
	assign control_o.wb_reg_valid  = mem_reg_i.valid && !mem_stall;

	assign control_o.mem_use_sb_snoop_data = valid_load && sb.snoop_hit;

	// A blocked store frees a slot by the next edge.
	assert property (@(posedge sb.clk_i) disable iff (sb.reset_i)
		store_on_full |=> !sb.full);
	assert property (@(posedge sb.clk_i) disable iff (sb.reset_i)
		sb.get_enable |-> !sb.empty);
endmodule

`default_nettype wire

// File: logic/store_buffer.sv
`default_nettype none
`timescale 1ns/100ps

module store_buffer #(
	parameter int SB_DEPTH   = 4,
	parameter int LINE_BYTES = 16
) (
	input  logic               clk_i,
	input  logic               reset_i,
	store_buffer_if.buffer     sb,
	input  logic        [31:0] put_addr_i,
	input  logic        [31:0] put_data_i,
	output logic               drain_valid_o,
	output logic        [31:0] drain_addr_o,
	output logic        [31:0] drain_data_o
);
	localparam int PTR_W    = $clog2(SB_DEPTH);
	localparam int CNT_W    = $clog2(SB_DEPTH + 1);
	localparam int LINE_LSB = $clog2(LINE_BYTES);

	logic [31:0]      addr_q [SB_DEPTH];
	logic [31:0]      data_q [SB_DEPTH];
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Queue
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (sb.put_enable)
				tail <= tail + 1'b1;
			if (sb.get_enable)
				head <= head + 1'b1;
			case ({sb.put_enable, sb.get_enable})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (sb.put_enable) begin
			addr_q[tail] <= put_addr_i;
			data_q[tail] <= put_data_i;
		end
	end

	assign sb.full  = (count == SB_DEPTH);
	assign sb.empty = (count == '0);

	// Head leaves on the same edge the dcache takes it.
	assign drain_valid_o = sb.get_enable;
	assign drain_addr_o  = addr_q[head];
	assign drain_data_o  = data_q[head];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Snoop
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		logic [PTR_W-1:0] idx;
		logic             line_match;

		sb.snoop_hit  = 1'b0;
		sb.snoop_data = '0;
		line_match    = 1'b0;
		idx           = head;

		// Oldest first, so a later match overrides with younger data.
		for (int i = 0; i < SB_DEPTH; i++) begin
			idx = head + PTR_W'(i);
			if (i < count) begin
				if (addr_q[idx][31:2] == sb.snoop_addr[31:2]) begin
					sb.snoop_hit  = 1'b1;
					sb.snoop_data = data_q[idx];
				end
				if (addr_q[idx][31:LINE_LSB] == sb.snoop_addr[31:LINE_LSB])
					line_match = 1'b1;
			end
		end

		sb.snoop_line_conflict = line_match && !sb.snoop_hit;
	end

	assert property (@(posedge clk_i) disable iff (reset_i) count <= SB_DEPTH);
	assert property (@(posedge clk_i) disable iff (reset_i) !(sb.put_enable && sb.full));
endmodule

`default_nettype wire

// File: logic/forwarding.sv
`default_nettype none
`timescale 1ns/100ps

module forwarding
	import definitions::*;
(
	input  pipeline_id_reg_t  id_reg_i,
	input  pipeline_ex_reg_t  ex_reg_i,
	input  pipeline_mem_reg_t mem_reg_i,
	input  pipeline_wb_reg_t  wb_reg_i,
	output alu_out_bypass_t   reg1_bypass_o,
	output alu_out_bypass_t   reg2_bypass_o
);
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [1:0] used;
	logic       ex_fwd_ok;
	logic       mem_fwd_ok;
	logic       wb_fwd_ok;
	logic [1:0] ex_hit;  // Bit 0 rs1, bit 1 rs2.
	logic [1:0] mem_hit;
	logic [1:0] wb_hit;

	function automatic alu_out_bypass_t pick(input logic ex, input logic mem, input logic wb);
		if (ex)
			return FROM_EX;
		if (mem)
			return FROM_MEM;
		if (wb)
			return FROM_WB;
		return FROM_NONE;
	endfunction

	assign rs1  = id_reg_i.instr.i_type.rs1;
	assign rs2  = id_reg_i.instr.s_type.rs2;
	assign used = src_regs_used(id_reg_i.instr.r_type.opcode);

	// Load data is not ready until MEM.
	assign ex_fwd_ok  = ex_reg_i.valid && ex_reg_i.regfile_we && !ex_reg_i.is_load;
	assign mem_fwd_ok = mem_reg_i.valid && mem_reg_i.regfile_we;
	assign wb_fwd_ok  = wb_reg_i.valid && wb_reg_i.regfile_we;

	assign ex_hit[0]  = ex_fwd_ok && data_hazard_raw_check(rs1, used[0], ex_reg_i.regfile_wr_addr);
	assign ex_hit[1]  = ex_fwd_ok && data_hazard_raw_check(rs2, used[1], ex_reg_i.regfile_wr_addr);
	assign mem_hit[0] = mem_fwd_ok &&
		data_hazard_raw_check(rs1, used[0], mem_reg_i.regfile_wr_addr);
	assign mem_hit[1] = mem_fwd_ok &&
		data_hazard_raw_check(rs2, used[1], mem_reg_i.regfile_wr_addr);
	assign wb_hit[0]  = wb_fwd_ok && data_hazard_raw_check(rs1, used[0], wb_reg_i.regfile_wr_addr);
	assign wb_hit[1]  = wb_fwd_ok && data_hazard_raw_check(rs2, used[1], wb_reg_i.regfile_wr_addr);

	assign reg1_bypass_o = pick(ex_hit[0], mem_hit[0], wb_hit[0]); // Youngest wins.
	assign reg2_bypass_o = pick(ex_hit[1], mem_hit[1], wb_hit[1]);
endmodule

`default_nettype wire

// File: logic/decode.sv
`default_nettype none
`timescale 1ns/100ps

module decode
	import definitions::*;
(
	input  instr_u      instr_i,
	output decode_out_t decode_o
);
	logic [6:0] opcode;

	assign opcode = instr_i.r_type.opcode; // Same place in every format.

	always_comb begin
		decode_o = '0;
		{decode_o.uses_rs2, decode_o.uses_rs1} = src_regs_used(opcode);
		decode_o.instr_class = CLASS_ALU;

		case (opcode)
			OPC_OP: begin
				decode_o.rs1 = instr_i.r_type.rs1;
				decode_o.rs2 = instr_i.r_type.rs2;
				decode_o.rd  = instr_i.r_type.rd;
			end
			OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
				decode_o.rs1 = instr_i.i_type.rs1;
				decode_o.rd  = instr_i.i_type.rd;
				if (opcode == OPC_LOAD)
					decode_o.instr_class = CLASS_LOAD;
				else if (opcode == OPC_JALR)
					decode_o.instr_class = CLASS_JUMP;
			end
			OPC_STORE: begin
				decode_o.rs1 = instr_i.s_type.rs1;
				decode_o.rs2 = instr_i.s_type.rs2;
				decode_o.instr_class = CLASS_STORE;
			end
			OPC_BRANCH: begin
				decode_o.rs1 = instr_i.b_type.rs1;
				decode_o.rs2 = instr_i.b_type.rs2;
				decode_o.instr_class = CLASS_BRANCH;
			end
			OPC_JAL: begin
				decode_o.rd = instr_i.i_type.rd; // J-type keeps rd here too.
				decode_o.instr_class = CLASS_JUMP;
			end
			OPC_LUI, OPC_AUIPC:
				decode_o.rd = instr_i.i_type.rd;
			default: ;
		endcase
	end
endmodule

`default_nettype wire

// File: logic/store_buffer_if.sv
`default_nettype none
`timescale 1ns/100ps

interface store_buffer_if (
	input logic clk_i,
	input logic reset_i
);
	logic        put_enable;
	logic        get_enable;
	logic [31:0] snoop_addr;
	logic        full;
	logic        empty;
	logic        snoop_hit;
	logic        snoop_line_conflict;
	logic [31:0] snoop_data;

	modport ctrl (
		input  clk_i, reset_i, full, empty, snoop_hit, snoop_line_conflict,
		output put_enable, get_enable, snoop_addr
	);

	modport buffer (
		input  put_enable, get_enable, snoop_addr,
		output full, empty, snoop_hit, snoop_line_conflict, snoop_data
	);
endinterface

`default_nettype wire

// File: logic/definitions.sv
`default_nettype none

package definitions;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// RV32I encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	localparam logic [2:0] CLASS_ALU    = 3'd0;
	localparam logic [2:0] CLASS_LOAD   = 3'd1;
	localparam logic [2:0] CLASS_STORE  = 3'd2;
	localparam logic [2:0] CLASS_BRANCH = 3'd3;
	localparam logic [2:0] CLASS_JUMP   = 3'd4;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_type;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_type;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_type;
		struct packed {
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			logic [6:0] opcode;
		} b_type;
	} instr_u;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage summaries
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic   valid;
		instr_u instr;
	} pipeline_id_reg_t;

	typedef struct packed {
		logic       valid;
		logic       regfile_we;
		logic [4:0] regfile_wr_addr;
		logic       is_load;
	} pipeline_ex_reg_t;

	typedef struct packed {
		logic        valid;
		logic        regfile_we;
		logic [4:0]  regfile_wr_addr;
		logic        is_jump;
		logic        is_branch;
		logic        cmp_unit_res; // Branch taken.
		logic        is_mem_access;
		logic        dcache_wr_enable;
		logic [31:0] addr;
		logic [31:0] wdata;
	} pipeline_mem_reg_t;

	typedef struct packed {
		logic       valid;
		logic       regfile_we;
		logic [4:0] regfile_wr_addr;
	} pipeline_wb_reg_t;

	typedef enum logic [1:0] {
		FROM_NONE,
		FROM_EX,
		FROM_MEM,
		FROM_WB
	} alu_out_bypass_t;

	typedef enum logic {
		PC_4,
		ALU_OUT
	} next_pc_sel_t;

	typedef struct packed {
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic       uses_rs1;
		logic       uses_rs2;
		logic [2:0] instr_class;
	} decode_out_t;

	typedef struct packed {
		alu_out_bypass_t reg1_bypass;
		alu_out_bypass_t reg2_bypass;
		next_pc_sel_t    next_pc_sel;
		logic            pc_reg_stall;
		logic            id_reg_stall;
		logic            ex_reg_stall;
		logic            mem_reg_stall;
		logic            id_reg_valid;
		logic            ex_reg_valid;
		logic            mem_reg_valid;
		logic            wb_reg_valid;
		logic            mem_use_sb_snoop_data;
	} pipeline_control_t;

	// Bit 0 is rs1, bit 1 is rs2.
	function automatic logic [1:0] src_regs_used(input logic [6:0] opcode);
		case (opcode)
			OPC_OP, OPC_STORE, OPC_BRANCH:  return 2'b11;
			OPC_OP_IMM, OPC_LOAD, OPC_JALR: return 2'b01;
			default:                        return 2'b00;
		endcase
	endfunction

	// x0 never carries a dependency.
	function automatic logic data_hazard_raw_check(
		input logic [4:0] src,
		input logic       used,
		input logic [4:0] wr_addr
	);
		return used && (wr_addr != 5'd0) && (wr_addr == src);
	endfunction

endpackage

`default_nettype wire
